// File: hdl/alu_pkg.sv
package alu_pkg;

	// ------------------------------
	// datapath width
	// ------------------------------

	localparam int unsigned alu_width = 32; // number of bit slices in the ripple chain

	typedef logic [alu_width-1:0] alu_word_t; // operands and result words share this type

	// ------------------------------
	// command and select encodings
	// ------------------------------

	// the three-bit command keeps the numbering of the original command table
	typedef enum logic [2:0] {
		op_add  = 3'd0, // a plus b
		op_sub  = 3'd1, // a plus inverted b plus one
		op_xor  = 3'd2,
		op_slt  = 3'd3, // signed compare built on the subtractor
		op_and  = 3'd4,
		op_nand = 3'd5,
		op_nor  = 3'd6,
		op_or   = 3'd7
	} alu_op_e;

	// each slice picks its output bit from one of these sources
	// add, sub and slt all read the adder sum
	typedef enum logic [2:0] {
		sel_sum  = 3'd0,
		sel_xor  = 3'd1,
		sel_and  = 3'd2,
		sel_nand = 3'd3,
		sel_nor  = 3'd4,
		sel_or   = 3'd5
	} alu_sel_e;

	// ------------------------------
	// broadcast control and flags
	// ------------------------------

	// decoded once at the top and fanned out to every slice and to the flag logic
	typedef struct packed {
		alu_sel_e sel;        // slice result source
		logic     sub;        // inverts b in every slice and feeds the carry into bit 0
		logic     slt_mode;   // only set for slt so the result collapses to one bit
		logic     arith_mode; // add and sub let carry and overflow through
	} alu_ctrl_t;

	// status bits that leave the ALU alongside the result word
	typedef struct packed {
		logic carry;    // carry out of the top slice
		logic overflow; // signed overflow of the top slice
		logic zero;     // whole conditioned result is zero
	} alu_flags_t;

endpackage

// File: hdl/alu_decoder.sv
module alu_decoder (
	input  logic               clk_i, // samples the control consistency check
	input  alu_pkg::alu_op_e   cmd_i,
	output alu_pkg::alu_ctrl_t ctrl_o
);

	// ------------------------------
	// command table
	// ------------------------------

	always_comb begin
		ctrl_o = '0; // logic operations keep every mode bit low
		unique case (cmd_i)
			alu_pkg::op_add: begin
				ctrl_o.sel        = alu_pkg::sel_sum;
				ctrl_o.arith_mode = 1'b1; // carry and overflow are meaningful here
			end
			alu_pkg::op_sub: begin
				ctrl_o.sel        = alu_pkg::sel_sum;
				ctrl_o.sub        = 1'b1; // two's complement of b through the adder chain
				ctrl_o.arith_mode = 1'b1;
			end
			alu_pkg::op_slt: begin
				// the compare runs a full subtract and only its sign survives
				ctrl_o.sel      = alu_pkg::sel_sum;
				ctrl_o.sub      = 1'b1;
				ctrl_o.slt_mode = 1'b1; // flags stay gated off in this mode
			end
			alu_pkg::op_xor:  ctrl_o.sel = alu_pkg::sel_xor;
			alu_pkg::op_and:  ctrl_o.sel = alu_pkg::sel_and;
			alu_pkg::op_nand: ctrl_o.sel = alu_pkg::sel_nand;
			alu_pkg::op_nor:  ctrl_o.sel = alu_pkg::sel_nor;
			alu_pkg::op_or:   ctrl_o.sel = alu_pkg::sel_or;
			default:          ctrl_o = '0; // only reachable with unknown inputs
		endcase
	end

	// ------------------------------
	// checks
	// ------------------------------

	// the slt rule downstream needs a real subtract on the sum path and no flag output
	a_slt_needs_sub: assert property (@(posedge clk_i)
		ctrl_o.slt_mode |-> (ctrl_o.sub && ctrl_o.sel == alu_pkg::sel_sum && !ctrl_o.arith_mode))
		else $error("slt mode decoded without subtract on the sum path");

endmodule

// File: hdl/alu_bitslice.sv
module alu_bitslice (
	input  logic               a_i,     // operand a bit
	input  logic               b_i,     // operand b bit before any inversion
	input  logic               carry_i, // carry from the slice below or the sub bit for bit 0
	input  alu_pkg::alu_ctrl_t ctrl_i,  // broadcast control from the decoder
	output logic               carry_o, // carry to the slice above
	output logic               result_o
);

	logic b_eff;    // b after the subtract inversion
	logic a_x_b;    // propagate term of the adder
	logic sum;      // full adder sum
	logic res_xor;
	logic res_and;
	logic res_nand;
	logic res_nor;
	logic res_or;

	// ------------------------------
	// full adder
	// ------------------------------

	assign b_eff   = b_i ^ ctrl_i.sub; // invert b for sub and slt
	assign a_x_b   = a_i ^ b_eff;
	assign sum     = a_x_b ^ carry_i;
	assign carry_o = (a_i & b_eff) | (a_x_b & carry_i); // generate or propagated carry

	// ------------------------------
	// bitwise operations
	// ------------------------------

	// the logic ops always see the uninverted b since sub is low for them anyway
	assign res_xor  = a_i ^ b_i;
	assign res_and  = a_i & b_i;
	assign res_nand = ~(a_i & b_i);
	assign res_nor  = ~(a_i | b_i);
	assign res_or   = a_i | b_i;

	// ------------------------------
	// result select
	// ------------------------------

	always_comb begin
		unique case (ctrl_i.sel)
			alu_pkg::sel_sum:  result_o = sum; // add, sub and slt
			alu_pkg::sel_xor:  result_o = res_xor;
			alu_pkg::sel_and:  result_o = res_and;
			alu_pkg::sel_nand: result_o = res_nand;
			alu_pkg::sel_nor:  result_o = res_nor;
			alu_pkg::sel_or:   result_o = res_or;
			default:           result_o = 1'b0; // the two unused select codes give a quiet zero
		endcase
	end

endmodule

// File: hdl/alu_flags.sv
module alu_flags (
	input  logic                clk_i,       // clocks the flag gating check
	input  logic                arst_n_i,    // holds the check off during reset
	input  alu_pkg::alu_word_t  raw_i,       // slice outputs before slt conditioning
	input  logic                carry_msb_i, // carry into the top slice
	input  logic                carry_out_i, // carry out of the top slice
	input  alu_pkg::alu_ctrl_t  ctrl_i,
	output alu_pkg::alu_word_t  result_o,    // conditioned result for the output register
	output alu_pkg::alu_flags_t flags_o
);

	logic ovf_raw;     // top slice carry mismatch in any mode
	logic neg_ovf;     // subtract wrapped from negative to positive
	logic neg_no_ovf;  // no wrap and the difference is negative
	logic less_than;   // a is below b as signed numbers

	// ------------------------------
	// signed less-than
	// ------------------------------

	assign ovf_raw = carry_msb_i ^ carry_out_i;

	// a carry out with no carry in means a negative a minus a positive b wrapped around
	assign neg_ovf    = carry_out_i & ~carry_msb_i;
	assign neg_no_ovf = ~ovf_raw & raw_i[alu_pkg::alu_width-1]; // the sign bit is trustworthy here
	assign less_than  = neg_ovf | neg_no_ovf;

	// ------------------------------
	// result conditioning
	// ------------------------------

	always_comb begin
		result_o = raw_i;
		if (ctrl_i.slt_mode) begin
			result_o    = '0;        // the difference itself is thrown away
			result_o[0] = less_than; // only the compare outcome is reported
		end
	end

	// ------------------------------
	// flags
	// ------------------------------

	assign flags_o.carry    = carry_out_i & ctrl_i.arith_mode; // only add and sub carry out
	assign flags_o.overflow = ovf_raw & ctrl_i.arith_mode;     // slt overflows internally but hides it
	assign flags_o.zero     = ~|result_o; // taken after conditioning so slt zero matches its result

	// the decoder and the gating above together keep logic ops and slt free of carry and overflow
	a_flags_gated: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_i.slt_mode || ctrl_i.sel != alu_pkg::sel_sum)
			|-> !(flags_o.carry || flags_o.overflow))
		else $error("carry or overflow raised outside add and sub");

endmodule

// File: hdl/alu_top.sv
module alu_top (
	input  logic                clk_i,
	input  logic                arst_n_i, // clears the output register
	input  alu_pkg::alu_word_t  op_a_i,   // operand a sampled every cycle
	input  alu_pkg::alu_word_t  op_b_i,   // operand b sampled every cycle
	input  alu_pkg::alu_op_e    cmd_i,    // command sampled with the operands
	output alu_pkg::alu_word_t  result_o, // result of the previous cycle's inputs
	output alu_pkg::alu_flags_t flags_o   // flags of the previous cycle's inputs
);

	alu_pkg::alu_ctrl_t         ctrl;        // decoded once and broadcast
	logic [alu_pkg::alu_width:0] carry_chain; // bit 0 is the sub carry and bit n+1 leaves slice n
	alu_pkg::alu_word_t         raw_result;  // straight out of the slices
	alu_pkg::alu_word_t         result_d;    // conditioned result before the register
	alu_pkg::alu_flags_t        flags_d;     // flags before the register

	// ------------------------------
	// decode
	// ------------------------------

	alu_decoder u_decoder (
		.clk_i  (clk_i),
		.cmd_i  (cmd_i),
		.ctrl_o (ctrl)
	);

	assign carry_chain[0] = ctrl.sub; // the plus one of two's complement enters here

	// ------------------------------
	// ripple chain of slices
	// ------------------------------

	for (genvar i = 0; i < alu_pkg::alu_width; i++) begin : g_slice
		alu_bitslice u_slice (
			.a_i      (op_a_i[i]),
			.b_i      (op_b_i[i]),
			.carry_i  (carry_chain[i]),
			.ctrl_i   (ctrl),
			.carry_o  (carry_chain[i+1]),
			.result_o (raw_result[i])
		);
	end

	// ------------------------------
	// conditioning and flags
	// ------------------------------

	alu_flags u_flags (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.raw_i       (raw_result),
		.carry_msb_i (carry_chain[alu_pkg::alu_width-1]), // carry into the top slice
		.carry_out_i (carry_chain[alu_pkg::alu_width]),   // carry out of the top slice
		.ctrl_i      (ctrl),
		.result_o    (result_d),
		.flags_o     (flags_d)
	);

	// ------------------------------
	// output register
	// ------------------------------

	// one cycle of latency with a new operation accepted every edge
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			result_o <= '0;
			flags_o  <= '0; // zero reads low while in reset as well
		end else begin
			result_o <= result_d;
			flags_o  <= flags_d;
		end
	end

	// once out of reset every output bit comes from the slice chain and must be resolved
	a_no_unknown_out: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!$isunknown({result_o, flags_o}))
		else $error("unknown value on result or flags");

endmodule

// File: test/alu_tb_ref.svh
`ifndef ALU_TB_REF_SVH
`define ALU_TB_REF_SVH

// registered outputs that one operand pair and command should produce
typedef struct packed {
	alu_pkg::alu_word_t  result;
	alu_pkg::alu_flags_t flags;
} expect_t;

localparam logic [31:0] rng_seed = 32'd99103; // start state of the random stream

// the adder is taken one bit wider so the carry falls out of the top
function automatic expect_t predict_alu(input alu_pkg::alu_word_t a,
		input alu_pkg::alu_word_t b, input alu_pkg::alu_op_e cmd);
	expect_t                    e;
	logic [alu_pkg::alu_width:0] wide;
	alu_pkg::alu_word_t         b_eff;
	logic                       sign_a;
	e = '0;
	case (cmd)
		alu_pkg::op_add, alu_pkg::op_sub: begin
			b_eff = (cmd == alu_pkg::op_sub) ? ~b : b; // sub adds the complement plus one
			wide = {1'b0, a} + {1'b0, b_eff} + ((cmd == alu_pkg::op_sub) ? 1 : 0);
			e.result = wide[alu_pkg::alu_width-1:0];
			e.flags.carry = wide[alu_pkg::alu_width];
			sign_a = a[alu_pkg::alu_width-1];
			// same input signs and a different result sign means the sum left the signed range
			e.flags.overflow = (sign_a == b_eff[alu_pkg::alu_width-1])
				&& (e.result[alu_pkg::alu_width-1] != sign_a);
		end
		alu_pkg::op_slt:  e.result = ($signed(a) < $signed(b)) ? 1 : 0;
		alu_pkg::op_xor:  e.result = a ^ b;
		alu_pkg::op_and:  e.result = a & b;
		alu_pkg::op_nand: e.result = ~(a & b);
		alu_pkg::op_nor:  e.result = ~(a | b);
		default:          e.result = a | b;
	endcase
	e.flags.zero = (e.result == '0); // taken from the final result for every command
	return e;
endfunction

// 32-bit xorshift with the 13, 17, 5 shift triple
function automatic logic [31:0] xorshift_next(input logic [31:0] x);
	logic [31:0] y;
	y = x;
	y = y ^ (y << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

`endif

// File: test/alu_tb.sv
module alu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	`include "alu_tb_ref.svh"

	localparam int clk_period    = 100;
	localparam int reset_cycles  = 5;
	localparam int n_add         = 7;
	localparam int n_sub         = 26; // six directed and twenty random
	localparam int n_slt         = 9;
	localparam int n_rand_all    = 200;
	localparam int n_tests       = 5; // each test also spends one closing cycle
	localparam int total_cycles  = reset_cycles + n_add + n_sub + n_slt + n_rand_all + n_tests;
	localparam int margin_cycles = 20;

	logic                clk = 1'b0;
	logic                arst_n;
	alu_pkg::alu_word_t  op_a;
	alu_pkg::alu_word_t  op_b;
	alu_pkg::alu_op_e    cmd;
	alu_pkg::alu_word_t  result;
	alu_pkg::alu_flags_t flags;

	logic        stim_valid;               // high while a test vector sits on the inputs
	int          cur_test;                 // index of the running test
	expect_t     exp_q;                    // model output for the inputs seen at the last edge
	logic        exp_valid_q = 1'b0;
	int          exp_test_q  = 0;          // test that the pending expectation belongs to
	logic [31:0] rng_state   = rng_seed;
	int          pass_cnt    = 0;
	int          fail_cnt    = 0;
	int          test_err [n_tests] = '{default: 0};

	always #(clk_period / 2) clk = ~clk;

	alu_top dut (
		.clk_i    (clk),
		.arst_n_i (arst_n),
		.op_a_i   (op_a),
		.op_b_i   (op_b),
		.cmd_i    (cmd),
		.result_o (result),
		.flags_o  (flags)
	);

	// ------------------------------
	// checking
	// ------------------------------

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual, input int test_idx);
		assert (actual === expected) pass_cnt += 1;
		else begin
			fail_cnt += 1;
			test_err[test_idx] += 1;
			$display("error %s expected 0x%0h got 0x%0h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic check_reset_outputs();
		check_value("result_o", '0, result, 0);
		check_value("flags_o", '0, flags, 0); // zero reads low too while the register is cleared
	endtask

	// the DUT register takes the inputs at this edge, so the model takes the same ones
	always @(posedge clk) begin
		exp_q       <= predict_alu(op_a, op_b, cmd);
		exp_valid_q <= stim_valid && arst_n;
		exp_test_q  <= cur_test;
	end

	// outputs only move on the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin
		if (exp_valid_q) begin
			check_value("result_o", exp_q.result, result, exp_test_q);
			check_value("flags_o.carry", exp_q.flags.carry, flags.carry, exp_test_q);
			check_value("flags_o.overflow", exp_q.flags.overflow, flags.overflow, exp_test_q);
			check_value("flags_o.zero", exp_q.flags.zero, flags.zero, exp_test_q);
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------

	function automatic logic [31:0] draw_random();
		rng_state = xorshift_next(rng_state);
		return rng_state;
	endfunction

	task automatic apply_vector(input alu_pkg::alu_word_t a, input alu_pkg::alu_word_t b,
			input alu_pkg::alu_op_e c);
		@(negedge clk);
		op_a       = a;
		op_b       = b;
		cmd        = c;
		stim_valid = 1'b1;
	endtask

	// the last vector of a test is checked on the next falling edge
	task automatic finish_test(input string name);
		@(negedge clk);
		stim_valid = 1'b0;
		#1;
		$display("test %0s finished with %0d errors", name, test_err[cur_test]);
		cur_test += 1;
	endtask

	initial begin
		alu_pkg::alu_word_t a_v;
		alu_pkg::alu_word_t b_v;
		logic [31:0]        r_v;
		arst_n     = 1'b0;
		op_a       = 32'h8000_0000; // would raise every flag if the reset let it through
		op_b       = 32'h8000_0000;
		cmd        = alu_pkg::op_add;
		stim_valid = 1'b0;
		cur_test   = 0;

		repeat (reset_cycles) begin
			@(negedge clk);
			check_reset_outputs();
		end
		arst_n = 1'b1; // half a cycle before the first capture
		#1;
		check_reset_outputs();
		finish_test("reset");

		apply_vector(32'h8000_0000, 32'h8000_0000, alu_pkg::op_add); // carry, overflow and zero
		apply_vector(32'h5000_0000, 32'h5000_0000, alu_pkg::op_add); // overflow without carry
		apply_vector(32'hffff_ffff, 32'h0000_0001, alu_pkg::op_add);
		apply_vector(32'h7fff_ffff, 32'h0000_0001, alu_pkg::op_add);
		apply_vector(32'h0000_0000, 32'h0000_0000, alu_pkg::op_add);
		apply_vector(32'h1234_5678, 32'h8765_4321, alu_pkg::op_add);
		apply_vector(32'hffff_ffff, 32'hffff_ffff, alu_pkg::op_add);
		finish_test("add_corners");

		apply_vector(32'h1234_5678, 32'h1234_5678, alu_pkg::op_sub); // zero and carry
		apply_vector(32'h0000_0000, 32'h0000_0001, alu_pkg::op_sub);
		apply_vector(32'h8000_0000, 32'h0000_0001, alu_pkg::op_sub);
		apply_vector(32'h7fff_ffff, 32'hffff_ffff, alu_pkg::op_sub);
		apply_vector(32'h0000_0005, 32'h0000_0003, alu_pkg::op_sub);
		apply_vector(32'h0000_0003, 32'h0000_0005, alu_pkg::op_sub);
		for (int i = 0; i < n_sub - 6; i++) begin
			a_v = draw_random();
			b_v = (i % 4 == 0) ? a_v : draw_random(); // every fourth pair is equal
			apply_vector(a_v, b_v, alu_pkg::op_sub);
		end
		finish_test("subtract");

		apply_vector(32'h0000_0005, 32'hffff_fffb, alu_pkg::op_slt); // positive against negative
		apply_vector(32'hffff_fffb, 32'h0000_0005, alu_pkg::op_slt);
		apply_vector(32'h0000_0003, 32'h0000_0004, alu_pkg::op_slt);
		apply_vector(32'h0000_0004, 32'h0000_0003, alu_pkg::op_slt);
		apply_vector(32'h0000_0004, 32'h0000_0004, alu_pkg::op_slt);
		apply_vector(32'h8000_0000, 32'h0000_0001, alu_pkg::op_slt); // difference wraps positive
		apply_vector(32'h7fff_ffff, 32'hffff_ffff, alu_pkg::op_slt); // difference wraps negative
		apply_vector(32'h8000_0000, 32'h7fff_ffff, alu_pkg::op_slt);
		apply_vector(32'h7fff_ffff, 32'h8000_0000, alu_pkg::op_slt);
		finish_test("set_less_than");

		// a new command every cycle, back to back
		for (int i = 0; i < n_rand_all; i++) begin
			a_v = draw_random();
			b_v = draw_random();
			r_v = draw_random();
			if (r_v[7:4] == 4'd0) b_v = a_v; // equal operands now and then for the zero flag
			apply_vector(a_v, b_v, alu_pkg::alu_op_e'(r_v[2:0]));
		end
		finish_test("random_stream");

		$display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// ------------------------------
	// watchdog
	// ------------------------------

	initial begin
		#((total_cycles + margin_cycles) * clk_period);
		$display("timeout, the run did not finish within %0d cycles", total_cycles + margin_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

// File: bitslice_alu.f
+incdir+test
hdl/alu_pkg.sv
hdl/alu_decoder.sv
hdl/alu_bitslice.sv
hdl/alu_flags.sv
hdl/alu_top.sv
test/alu_tb.sv

// File: Bender.yml
package:
  name: bitslice_alu

sources:
  - files:
      - hdl/alu_pkg.sv
      - hdl/alu_decoder.sv
      - hdl/alu_bitslice.sv
      - hdl/alu_flags.sv
      - hdl/alu_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/alu_tb.sv
